// File: dv/ftdi_host_model.sv
`timescale 1ns/1ns
`default_nettype none

`include "rom_link_defines.svh"

module ftdi_host_model (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 txe_stall,
    input  logic                 rxf_stall,
    input  logic                 wr_n,
    input  logic                 siwu_n,
    input  logic                 oe_n,
    input  logic                 rd_n,
    input  link_pkg::link_byte_t adbus_out,
    input  logic                 adbus_oe,
    output logic                 txe_n,
    output logic                 rxf_n,
    output link_pkg::link_byte_t adbus_in,
    output int                   error_count,
    output int                   cmd_count,
    output tl_pkg::tl_addr_t     cmd_addr,
    output tl_pkg::tl_source_t   cmd_tag,
    output logic                 flush_pending
);
    import link_pkg::*;

    link_byte_t cmd_buf [5];
    int         cmd_idx;
    link_byte_t rsp_q [$];

    initial begin
        txe_n         = 1'b1;
        rxf_n         = 1'b1;
        adbus_in      = '0;
        error_count   = 0;
        cmd_count     = 0;
        cmd_idx       = 0;
        cmd_addr      = '0;
        cmd_tag       = '0;
        flush_pending = 1'b0;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Strobes are taken at the rising edge.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        if (!rst_n) begin
            rsp_q.delete();
            cmd_idx       = 0;
            flush_pending = 1'b0;
        end else begin
            assert (!(adbus_oe && !oe_n)) else begin
                $display("Bus conflict: the host and the bridge drive the data bus together");
                error_count++;
            end
            if (!rd_n && rsp_q.size() != 0) begin
                void'(rsp_q.pop_front());   // Byte consumed by the bridge.
            end
            if (!siwu_n) begin
                assert (wr_n) else begin
                    $display("Send-immediate pulsed in the same cycle as a write strobe");
                    error_count++;
                end
                assert (flush_pending) else begin
                    $display("Send-immediate pulsed with no byte written since the last one");
                    error_count++;
                end
                flush_pending = 1'b0;
            end
            if (!wr_n) begin
                assert (adbus_oe) else begin
                    $display("Write strobe seen while the bridge does not drive the bus");
                    error_count++;
                end
                flush_pending    = 1'b1;
                cmd_buf[cmd_idx] = adbus_out;
                cmd_idx++;
                if (cmd_idx == 5) begin
                    cmd_idx  = 0;
                    cmd_addr = {cmd_buf[3], cmd_buf[2], cmd_buf[1]};
                    cmd_tag  = cmd_buf[4];
                    cmd_count++;
                    assert (cmd_buf[0] == `CMD_READ) else begin
                        $display("Malformed command: first byte %h is not the read opcode",
                                 cmd_buf[0]);
                        error_count++;
                    end
                    assert (cmd_buf[1][2:0] == 3'b000) else begin
                        $display("Malformed command: address byte %h is not word aligned",
                                 cmd_buf[1]);
                        error_count++;
                    end
                    for (int k = 0; k < 8; k++) begin
                        rsp_q.push_back((cmd_buf[1] + 8'(k)) ^ 8'h5A);
                    end
                end
            end
        end
    end

    // Pins toward the bridge change on the falling edge.
    always @(negedge clk) begin
        txe_n    <= txe_stall;
        rxf_n    <= !(rsp_q.size() != 0 && !rxf_stall);
        adbus_in <= (rsp_q.size() != 0) ? rsp_q[0] : 8'h00;
    end

endmodule

`default_nettype wire

// File: dv/rom_link_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "rom_link_defines.svh"

module rom_link_tb;
    import tl_pkg::*;
    import link_pkg::*;

    localparam int N_REQ          = 48;
    localparam int TIMEOUT_CYCLES = N_REQ * 200 + 1000;

    logic       clk;
    logic       rst_n;
    logic       a_valid;
    logic       a_ready;
    tl_a_req_t  a_req;
    logic       d_valid;
    logic       d_ready;
    tl_d_rsp_t  d_rsp;
    logic       rxf_n;
    logic       txe_n;
    logic       oe_n;
    logic       rd_n;
    logic       wr_n;
    logic       siwu_n;
    link_byte_t adbus_in;
    link_byte_t adbus_out;
    logic       adbus_oe;
    logic       txe_stall;
    logic       rxf_stall;
    int         host_errors;
    int         host_cmds;
    tl_addr_t   host_cmd_addr;
    tl_source_t host_cmd_tag;
    logic       host_flush_pending;

    logic [15:0] lfsr;
    tl_a_req_t   req_list [N_REQ];
    int          gap_list [N_REQ];
    tl_d_rsp_t   exp_q [$];
    tl_a_req_t   cmd_q [$];
    int          pass_count;
    int          fail_count;
    int          rsp_count;
    int          aligned_count;
    int          cmds_checked;
    int          cycles;
    int          hold_errors;
    logic        hold_prev;
    tl_d_rsp_t   rsp_prev;

    rom_link_top dut_i (
        .clk(clk), .rst_n(rst_n),
        .a_valid(a_valid), .a_ready(a_ready), .a_req(a_req),
        .d_valid(d_valid), .d_ready(d_ready), .d_rsp(d_rsp),
        .rxf_n(rxf_n), .txe_n(txe_n), .oe_n(oe_n), .rd_n(rd_n),
        .wr_n(wr_n), .siwu_n(siwu_n),
        .adbus_in(adbus_in), .adbus_out(adbus_out), .adbus_oe(adbus_oe)
    );

    ftdi_host_model host_i (
        .clk(clk), .rst_n(rst_n),
        .txe_stall(txe_stall), .rxf_stall(rxf_stall),
        .wr_n(wr_n), .siwu_n(siwu_n), .oe_n(oe_n), .rd_n(rd_n),
        .adbus_out(adbus_out), .adbus_oe(adbus_oe),
        .txe_n(txe_n), .rxf_n(rxf_n), .adbus_in(adbus_in),
        .error_count(host_errors), .cmd_count(host_cmds),
        .cmd_addr(host_cmd_addr), .cmd_tag(host_cmd_tag),
        .flush_pending(host_flush_pending)
    );

    always #5 clk = !clk;

    // Taps 16, 14, 13, 11. One step per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic tl_d_rsp_t expected_rsp(input tl_a_req_t req);
        tl_d_rsp_t rsp;
        rsp.opcode = TL_ACCESS_ACK_DATA;
        rsp.source = req.source;
        rsp.denied = (req.address[2:0] != 3'b000);
        rsp.data   = '0;
        if (!rsp.denied) begin
            for (int k = 0; k < 8; k++) begin
                rsp.data[k*8 +: 8] = (req.address[7:0] + 8'(k)) ^ 8'h5A;
            end
        end
        return rsp;
    endfunction

    function automatic void report_test(input string name, input logic ok);
        if (ok) begin
            pass_count++;
            $display("%s: passed", name);
        end else begin
            fail_count++;
            $display("%s: failed", name);
        end
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // D channel monitor, hold check and timeout.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        tl_d_rsp_t exp;
        string     name;
        logic      ok;
        if (rst_n) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("Timeout: only %0d of %0d responses arrived", rsp_count, N_REQ);
                $display("Test FAILED");
                $finish;
            end else begin
                if (hold_prev) begin
                    assert (d_valid && d_rsp == rsp_prev) else begin
                        $display("Held D response changed or vanished before d_ready");
                        hold_errors++;
                    end
                end
                hold_prev = d_valid && !d_ready;
                rsp_prev  = d_rsp;
                if (d_valid && d_ready) begin
                    name = $sformatf("read_%0d", rsp_count);
                    ok   = 1'b1;
                    assert (exp_q.size() != 0) else begin
                        $display("%s arrived with no read outstanding", name);
                        ok = 1'b0;
                    end
                    if (exp_q.size() != 0) begin
                        exp = exp_q.pop_front();
                        assert (d_rsp.opcode == exp.opcode) else begin
                            $display("** Error %s opcode expected %0d actual %0d",
                                     name, exp.opcode, d_rsp.opcode);
                            ok = 1'b0;
                        end
                        assert (d_rsp.source == exp.source) else begin
                            $display("** Error %s source expected %h actual %h",
                                     name, exp.source, d_rsp.source);
                            ok = 1'b0;
                        end
                        assert (d_rsp.denied == exp.denied) else begin
                            $display("** Error %s denied expected %b actual %b",
                                     name, exp.denied, d_rsp.denied);
                            ok = 1'b0;
                        end
                        assert (d_rsp.data == exp.data) else begin
                            $display("** Error %s data expected %h actual %h",
                                     name, exp.data, d_rsp.data);
                            ok = 1'b0;
                        end
                    end
                    report_test(name, ok);
                    rsp_count++;
                end
            end
        end
    end

    // Random stalls on the host pins and on d_ready.
    always @(negedge clk) begin
        if (rst_n) begin
            txe_stall <= (rand_bits(2) == 0);
            rxf_stall <= (rand_bits(2) == 0);
            d_ready   <= (rand_bits(2) != 0);
        end
    end

    // Every command parsed by the host must match the next aligned read that was accepted.
    always @(negedge clk) begin
        tl_a_req_t want;
        string     name;
        logic      ok;
        if (rst_n && host_cmds != cmds_checked) begin
            name = $sformatf("command_%0d", cmds_checked);
            ok   = 1'b1;
            assert (cmd_q.size() != 0) else begin
                $display("%s reached the host with no aligned read accepted", name);
                ok = 1'b0;
            end
            if (cmd_q.size() != 0) begin
                want = cmd_q.pop_front();
                assert (host_cmd_addr == want.address) else begin
                    $display("** Error %s address expected %h actual %h",
                             name, want.address, host_cmd_addr);
                    ok = 1'b0;
                end
                assert (host_cmd_tag == want.source) else begin
                    $display("** Error %s tag expected %h actual %h",
                             name, want.source, host_cmd_tag);
                    ok = 1'b0;
                end
            end
            report_test(name, ok);
            cmds_checked++;
        end
    end

    initial begin
        logic ok;
        clk           = 1'b0;
        rst_n         = 1'b0;
        a_valid       = 1'b0;
        a_req         = '0;
        d_ready       = 1'b0;
        txe_stall     = 1'b1;
        rxf_stall     = 1'b1;
        lfsr          = 16'd80;
        pass_count    = 0;
        fail_count    = 0;
        rsp_count     = 0;
        aligned_count = 0;
        cmds_checked  = 0;
        cycles        = 0;
        hold_errors   = 0;
        hold_prev     = 1'b0;
        rsp_prev      = '0;

        for (int i = 0; i < N_REQ; i++) begin
            req_list[i].opcode  = TL_GET;
            req_list[i].address = tl_addr_t'(rand_bits(`ROM_ADDR_W)) & ~tl_addr_t'(7);
            if (rand_bits(3) == 0) begin   // One in eight misaligned.
                req_list[i].address[2:0] = 3'(rand_bits(2)) + 3'd1;
            end
            req_list[i].source = tl_source_t'(rand_bits(8));
            gap_list[i]        = int'(rand_bits(2));
        end

        repeat (4) @(posedge clk);
        @(negedge clk);

        ok = 1'b1;
        assert (wr_n && rd_n && oe_n && siwu_n) else begin
            $display("A strobe pin is low after reset");
            ok = 1'b0;
        end
        assert (!adbus_oe && !a_ready && !d_valid) else begin
            $display("adbus_oe, a_ready or d_valid is high after reset");
            ok = 1'b0;
        end
        report_test("after_reset", ok);

        rst_n = 1'b1;
        @(negedge clk);

        for (int i = 0; i < N_REQ; i++) begin
            repeat (gap_list[i]) @(negedge clk);
            a_req   = req_list[i];
            a_valid = 1'b1;
            do begin
                @(posedge clk);
            end while (!a_ready);
            exp_q.push_back(expected_rsp(req_list[i]));
            if (req_list[i].address[2:0] == 3'b000) begin
                aligned_count++;
                cmd_q.push_back(req_list[i]);
            end
            @(negedge clk);
            a_valid = 1'b0;
        end

        while (rsp_count < N_REQ) begin
            @(posedge clk);
        end
        @(negedge clk);

        assert (host_cmds == aligned_count) else begin
            $display("** Error command_count expected %0d actual %0d",
                     aligned_count, host_cmds);
        end
        report_test("command_count", host_cmds == aligned_count);
        assert (!host_flush_pending) else begin
            $display("Command bytes were left without a send-immediate pulse after them");
        end
        report_test("host_protocol", host_errors == 0 && !host_flush_pending);
        report_test("hold_stable", hold_errors == 0);

        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+logic
logic/tl_pkg.sv
logic/link_pkg.sv
logic/byte_fifo.sv
logic/ftdi_wr.sv
logic/ftdi_rd.sv
logic/rom_front.sv
logic/rom_link_top.sv
dv/ftdi_host_model.sv
dv/rom_link_tb.sv

// File: logic/byte_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "rom_link_defines.svh"

module byte_fifo (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  link_pkg::link_byte_t in_data,
    output logic                 out_valid,
    input  logic                 out_ready,
    output link_pkg::link_byte_t out_data
);
    import link_pkg::*;

    localparam int DEPTH = `BYTE_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    link_byte_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    fifo_level_t      level;
    logic             push;
    logic             pop;

    assign in_ready  = (level != fifo_level_t'(DEPTH));
    assign out_valid = (level != '0);
    assign out_data  = mem[rd_ptr];   // Head entry, valid one cycle after its push.

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;   // Both or neither.
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/ftdi_rd.sv
`timescale 1ns/1ns
`default_nettype none

module ftdi_rd (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rxf_n,
    output logic                 oe_n,
    output logic                 rd_n,
    input  link_pkg::link_byte_t adbus_in,
    input  logic                 bus_busy,
    output logic                 out_valid,
    input  logic                 out_ready,
    output link_pkg::link_byte_t out_data
);
    import link_pkg::*;

    ftdi_rd_state_e state;
    logic           own_bus;

    // The writer has priority, so the pins let go in the same cycle it drives.
    assign own_bus = (state != RD_IDLE) && !bus_busy;
    assign oe_n    = !own_bus;

    assign out_valid = (state == RD_READ) && !rxf_n && !bus_busy;
    assign out_data  = adbus_in;
    assign rd_n      = !(out_valid && out_ready);   // Only advance a byte that is taken.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Turnaround then streaming.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (!rxf_n && !bus_busy && out_ready) begin
                        state <= RD_TURN;
                    end
                end
                RD_TURN: begin
                    // oe_n has been low for one cycle, the host now drives the bus.
                    if (rxf_n || bus_busy) begin
                        state <= RD_IDLE;
                    end else begin
                        state <= RD_READ;
                    end
                end
                RD_READ: begin
                    if (rxf_n || bus_busy || !out_ready) begin
                        state <= RD_IDLE;
                    end
                end
                default: begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/ftdi_wr.sv
`timescale 1ns/1ns
`default_nettype none

module ftdi_wr (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 txe_n,
    output logic                 wr_n,
    output logic                 siwu_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  link_pkg::link_byte_t in_data,
    output link_pkg::link_byte_t adbus_out,
    output logic                 adbus_oe
);
    import link_pkg::*;

    ftdi_wr_state_e state;
    logic           send;

    // A byte goes out in any cycle where the host has room and the queue has one.
    assign in_ready  = (state != WR_FLUSH) && !txe_n;
    assign send      = in_valid && in_ready;

    assign adbus_oe  = send;
    assign adbus_out = in_data;
    assign wr_n      = !send;   // One strobe per byte.
    assign siwu_n    = (state != WR_FLUSH);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Burst tracking. Once the queue runs dry after a burst, send-immediate
    // is pulsed for one cycle so the host does not sit on a partial packet.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (send) begin
                        state <= WR_BURST;
                    end
                end
                WR_BURST: begin
                    if (!in_valid) begin
                        state <= WR_FLUSH;   // Last byte already left.
                    end
                end
                WR_FLUSH: begin
                    state <= WR_IDLE;
                end
                default: begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/link_pkg.sv
`default_nettype none

`include "rom_link_defines.svh"

package link_pkg;

    typedef logic [7:0] link_byte_t;

    // One extra bit so that a full FIFO can be told from an empty one.
    typedef logic [$clog2(`BYTE_FIFO_DEPTH+1)-1:0] fifo_level_t;

    typedef enum logic [1:0] {WR_IDLE, WR_BURST, WR_FLUSH} ftdi_wr_state_e;

    typedef enum logic [1:0] {RD_IDLE, RD_TURN, RD_READ} ftdi_rd_state_e;

    typedef enum logic [1:0] {TX_IDLE, TX_CMD, TX_DENY} front_tx_state_e;

endpackage

`default_nettype wire

// File: logic/rom_front.sv
`timescale 1ns/1ns
`default_nettype none

`include "rom_link_defines.svh"

module rom_front (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 a_valid,
    output logic                 a_ready,
    input  tl_pkg::tl_a_req_t    a_req,
    output logic                 d_valid,
    input  logic                 d_ready,
    output tl_pkg::tl_d_rsp_t    d_rsp,
    output logic                 cmd_valid,
    input  logic                 cmd_ready,
    output link_pkg::link_byte_t cmd_data,
    input  logic                 rsp_valid,
    output logic                 rsp_ready,
    input  link_pkg::link_byte_t rsp_data
);
    import tl_pkg::*;
    import link_pkg::*;

    localparam int TAG_N     = `OUTSTANDING_MAX;
    localparam int TAG_PTR_W = $clog2(TAG_N);
    localparam int TAG_CNT_W = $clog2(TAG_N + 1);

    front_tx_state_e      tx_state;
    tl_addr_t             cmd_addr;
    tl_source_t           cmd_source;
    logic [2:0]           cmd_idx;
    logic                 aligned;
    logic                 a_fire;
    logic                 deny_fire;

    tl_source_t           tag_mem [TAG_N];
    logic [TAG_PTR_W-1:0] tag_wr_ptr;
    logic [TAG_PTR_W-1:0] tag_rd_ptr;
    logic [TAG_CNT_W-1:0] tag_count;
    logic                 tag_push;
    logic                 tag_pop;

    tl_data_t             rx_word;
    logic [2:0]           rx_cnt;
    logic                 rsp_fire;
    logic                 rx_last;
    logic                 d_fire;

    assign aligned = (a_req.address[2:0] == 3'b000);

    // A misaligned read waits until the D channel has nothing older to return.
    assign a_ready = rst_n
                  && (tx_state == TX_IDLE)
                  && (tag_count < TAG_CNT_W'(TAG_N))
                  && (aligned || (tag_count == '0));

    assign a_fire    = a_valid && a_ready;
    assign deny_fire = a_fire && !aligned;
    assign d_fire    = d_valid && d_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Command side.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign cmd_valid = (tx_state == TX_CMD);

    always_comb begin
        case (cmd_idx)
            3'd0:    cmd_data = `CMD_READ;
            3'd1:    cmd_data = cmd_addr[7:0];
            3'd2:    cmd_data = cmd_addr[15:8];
            3'd3:    cmd_data = cmd_addr[23:16];
            default: cmd_data = cmd_source;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_state <= TX_IDLE;
            cmd_idx  <= '0;
        end else begin
            case (tx_state)
                TX_IDLE: begin
                    if (a_fire) begin
                        cmd_idx  <= '0;
                        tx_state <= aligned ? TX_CMD : TX_DENY;
                    end
                end
                TX_CMD: begin
                    if (cmd_ready) begin
                        cmd_idx <= cmd_idx + 1'b1;
                        if (cmd_idx == 3'd4) begin
                            tx_state <= TX_IDLE;   // Tag byte sent.
                        end
                    end
                end
                TX_DENY: begin
                    if (d_fire) begin
                        tx_state <= TX_IDLE;
                    end
                end
                default: begin
                    tx_state <= TX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (a_fire) begin
            cmd_addr   <= a_req.address;
            cmd_source <= a_req.source;
        end
    end

    // Tags stay queued until their response has left on D.
    assign tag_push = a_fire && aligned;
    assign tag_pop  = d_fire && !d_rsp.denied;

    always_ff @(posedge clk) begin
        if (tag_push) begin
            tag_mem[tag_wr_ptr] <= a_req.source;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag_wr_ptr <= '0;
            tag_rd_ptr <= '0;
            tag_count  <= '0;
        end else begin
            if (tag_push) begin
                tag_wr_ptr <= tag_wr_ptr + 1'b1;
            end
            if (tag_pop) begin
                tag_rd_ptr <= tag_rd_ptr + 1'b1;
            end
            case ({tag_push, tag_pop})
                2'b10:   tag_count <= tag_count + 1'b1;
                2'b01:   tag_count <= tag_count - 1'b1;
                default: tag_count <= tag_count;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Response side. Bytes arrive LSB first.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign rsp_ready = !d_valid;   // Stall the host while D is held.
    assign rsp_fire  = rsp_valid && rsp_ready;
    assign rx_last   = rsp_fire && (rx_cnt == 3'd7);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_cnt  <= '0;
            d_valid <= 1'b0;
        end else begin
            if (rsp_fire) begin
                rx_cnt <= rx_cnt + 1'b1;
            end
            if (d_fire) begin
                d_valid <= 1'b0;
            end else if (rx_last || deny_fire) begin
                d_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_fire) begin
            rx_word <= {rsp_data, rx_word[63:8]};
        end
        if (deny_fire) begin
            d_rsp <= '{opcode: TL_ACCESS_ACK_DATA, source: a_req.source,
                       denied: 1'b1, data: '0};
        end else if (rx_last) begin
            d_rsp <= '{opcode: TL_ACCESS_ACK_DATA, source: tag_mem[tag_rd_ptr],
                       denied: 1'b0, data: {rsp_data, rx_word[63:8]}};
        end
    end

endmodule

`default_nettype wire

// File: logic/rom_link_defines.svh
`ifndef ROM_LINK_DEFINES_SVH
`define ROM_LINK_DEFINES_SVH

// Byte address width on the bus side.
`define ROM_ADDR_W 24

// Reads that may wait for host data at once.
`define OUTSTANDING_MAX 4

// Entries in each byte FIFO. Must be a power of two.
`define BYTE_FIFO_DEPTH 16

// First byte of every command sent to the host.
`define CMD_READ 8'h01

`endif

// File: logic/rom_link_top.sv
`timescale 1ns/1ns
`default_nettype none

module rom_link_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 a_valid,
    output logic                 a_ready,
    input  tl_pkg::tl_a_req_t    a_req,
    output logic                 d_valid,
    input  logic                 d_ready,
    output tl_pkg::tl_d_rsp_t    d_rsp,
    input  logic                 rxf_n,
    input  logic                 txe_n,
    output logic                 oe_n,
    output logic                 rd_n,
    output logic                 wr_n,
    output logic                 siwu_n,
    input  link_pkg::link_byte_t adbus_in,
    output link_pkg::link_byte_t adbus_out,
    output logic                 adbus_oe
);
    import link_pkg::*;

    // Command path, front to FIFO to writer.
    logic       cmd_in_valid;
    logic       cmd_in_ready;
    link_byte_t cmd_in_data;
    logic       cmd_out_valid;
    logic       cmd_out_ready;
    link_byte_t cmd_out_data;

    // Response path, reader to FIFO to front.
    logic       rsp_in_valid;
    logic       rsp_in_ready;
    link_byte_t rsp_in_data;
    logic       rsp_out_valid;
    logic       rsp_out_ready;
    link_byte_t rsp_out_data;

    rom_front rom_front_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .a_valid   (a_valid),
        .a_ready   (a_ready),
        .a_req     (a_req),
        .d_valid   (d_valid),
        .d_ready   (d_ready),
        .d_rsp     (d_rsp),
        .cmd_valid (cmd_in_valid),
        .cmd_ready (cmd_in_ready),
        .cmd_data  (cmd_in_data),
        .rsp_valid (rsp_out_valid),
        .rsp_ready (rsp_out_ready),
        .rsp_data  (rsp_out_data)
    );

    byte_fifo cmd_fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (cmd_in_valid),
        .in_ready  (cmd_in_ready),
        .in_data   (cmd_in_data),
        .out_valid (cmd_out_valid),
        .out_ready (cmd_out_ready),
        .out_data  (cmd_out_data)
    );

    byte_fifo rsp_fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (rsp_in_valid),
        .in_ready  (rsp_in_ready),
        .in_data   (rsp_in_data),
        .out_valid (rsp_out_valid),
        .out_ready (rsp_out_ready),
        .out_data  (rsp_out_data)
    );

    ftdi_wr ftdi_wr_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .txe_n     (txe_n),
        .wr_n      (wr_n),
        .siwu_n    (siwu_n),
        .in_valid  (cmd_out_valid),
        .in_ready  (cmd_out_ready),
        .in_data   (cmd_out_data),
        .adbus_out (adbus_out),
        .adbus_oe  (adbus_oe)
    );

    ftdi_rd ftdi_rd_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rxf_n     (rxf_n),
        .oe_n      (oe_n),
        .rd_n      (rd_n),
        .adbus_in  (adbus_in),
        .bus_busy  (adbus_oe),   // Writer owns the pad this cycle.
        .out_valid (rsp_in_valid),
        .out_ready (rsp_in_ready),
        .out_data  (rsp_in_data)
    );

endmodule

`default_nettype wire

// File: logic/tl_pkg.sv
`default_nettype none

`include "rom_link_defines.svh"

package tl_pkg;

    typedef logic [`ROM_ADDR_W-1:0] tl_addr_t;
    typedef logic [63:0]            tl_data_t;
    typedef logic [7:0]             tl_source_t;

    // Encodings follow the TileLink opcode tables.
    typedef enum logic [2:0] {
        TL_ACCESS_ACK_DATA = 3'd1,  // D channel.
        TL_GET             = 3'd4   // A channel.
    } tl_opcode_e;

    typedef struct packed {
        tl_opcode_e opcode;
        tl_addr_t   address;
        tl_source_t source;
    } tl_a_req_t;

    typedef struct packed {
        tl_opcode_e opcode;
        tl_source_t source;
        logic       denied;
        tl_data_t   data;
    } tl_d_rsp_t;

endpackage

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build the ROM link testbench with Verilator and run it into sim.log.

cd "$(dirname "$0")" || exit 1

verilator --binary -f list.f --top-module rom_link_tb -o rom_link_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rom_link_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "Simulation exited with an error status"
    exit 1
fi

cat sim.log

if grep -q "Test FAILED" sim.log; then
    exit 1
fi

if ! grep -q "Test OK" sim.log; then
    echo "Simulation ended without a verdict"
    exit 1
fi

exit 0
